/* sources.f */
+incdir+include
logic/rv_fetch_pkg.sv
logic/min_idx.sv
logic/rv_fetch_branch_pred.sv
logic/rv_fetch_pc.sv
logic/rv_fetch.sv
verification/rv_fetch_checker.sv
verification/tb_rv_fetch.sv

/* Makefile */
TOP := tb_rv_fetch

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary -j 0 --timescale 1ns/1ps --top-module $(TOP) \
		-f sources.f -Mdir obj_dir -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

/* verification/tb_rv_fetch.sv */
`timescale 1ns/1ps

`include "rv_fetch_cfg.svh"

module tb_rv_fetch;

    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_CYCLES = 33;
    localparam int RANDOM_CYCLES   = 4000;
    localparam int CYCLE_LIMIT     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 100;
    localparam int BRANCH_POOL     = 20;     // More branches than BTB entries
    localparam int TARGET_POOL     = 32;

    logic                       clk;
    logic                       reset_n;
    rv_fetch_pkg::redirect_t    redirect;
    logic                       stall;
    rv_fetch_pkg::fetch_t       fetch;
    int                         error_count;
    int                         check_count;
    int                         cycle_count;

    always #20 clk = ~clk;

    rv_fetch u_rv_fetch
    (
        .i_clk          (clk),
        .i_reset_n      (reset_n),
        .i_redirect     (redirect),
        .i_stall        (stall),
        .o_fetch        (fetch)
    );

    rv_fetch_checker u_checker
    (
        .i_clk          (clk),
        .i_reset_n      (reset_n),
        .i_redirect     (redirect),
        .i_stall        (stall),
        .i_fetch        (fetch),
        .o_errors       (error_count),
        .o_checks       (check_count)
    );

    // One cycle of stimulus, applied on the falling edge
    task automatic drive_cycle(input logic fire,
                               input logic [`RV_IADDR_BITS-1:0] branch_pc,
                               input logic [`RV_IADDR_BITS-1:0] target,
                               input logic hold);
        @(negedge clk);
        redirect.valid     = fire;
        redirect.branch_pc = branch_pc;
        redirect.target    = target;
        stall              = hold;
    endtask

    initial
    begin
        logic                       fire;
        logic                       hold;
        logic [`RV_IADDR_BITS-1:0]  branch_pc;
        logic [`RV_IADDR_BITS-1:0]  target;

        void'($urandom(14));
        clk      = 1'b0;
        reset_n  = 1'b0;
        redirect = '0;
        stall    = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;

        repeat (8) drive_cycle(1'b0, '0, '0, 1'b0);     // Sequential run
        drive_cycle(1'b1, 32'h10, 32'h40, 1'b1);         // Redirect under stall
        repeat (3) drive_cycle(1'b0, '0, '0, 1'b1);
        drive_cycle(1'b1, 32'h44, 32'h08, 1'b0);
        repeat (12) drive_cycle(1'b0, '0, '0, 1'b0);    // Loop through two trained branches
        drive_cycle(1'b1, 32'h10, 32'h60, 1'b0);         // Retrain with new target
        drive_cycle(1'b1, 32'h5C, 32'h0C, 1'b0);
        repeat (6) drive_cycle(1'b0, '0, '0, 1'b0);

        for (int n = 0; n < RANDOM_CYCLES; n++)
        begin
            fire      = ($urandom % 4) == 0;
            hold      = ($urandom % 5) == 0;
            branch_pc = ($urandom % BRANCH_POOL) * 4;
            target    = (1 + $urandom % (TARGET_POOL - 1)) * 4;
            drive_cycle(fire, branch_pc, target, hold);
        end

        repeat (2) drive_cycle(1'b0, '0, '0, 1'b0);
        @(negedge clk);

        $display("errors: %0d, checks: %0d", error_count, check_count);
        if (error_count == 0 && check_count > 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog
    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run timed out after %0d cycles", cycle_count);
        $display("errors: %0d, checks: %0d", error_count, check_count);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* verification/rv_fetch_checker.sv */
`timescale 1ns/1ps

`include "rv_fetch_cfg.svh"

module rv_fetch_checker
(
    input   logic                       i_clk,
    input   logic                       i_reset_n,
    input   rv_fetch_pkg::redirect_t    i_redirect,
    input   logic                       i_stall,
    input   rv_fetch_pkg::fetch_t       i_fetch,
    output  int                         o_errors,
    output  int                         o_checks
);

    localparam int ENTRIES = 1 << `RV_BTB_SIZE_BITS;

    logic [`RV_IADDR_BITS-1:0]  ref_pc     [ENTRIES];
    logic [`RV_IADDR_BITS-1:0]  ref_target [ENTRIES];
    logic [ENTRIES-1:0]         ref_hist   [ENTRIES];     // MSB newest

    rv_fetch_pkg::fetch_t       expected;
    logic                       armed = 1'b0;
    int                         error_count = 0;
    int                         check_count = 0;

    assign o_errors = error_count;
    assign o_checks = check_count;

    // Next fetch by priority of redirect, stall, BTB hit and sequential
    function automatic rv_fetch_pkg::fetch_t next_fetch(input rv_fetch_pkg::fetch_t cur,
                                                         input rv_fetch_pkg::redirect_t rd,
                                                         input logic stall);
        rv_fetch_pkg::fetch_t nxt;

        nxt.pc        = cur.pc + 32'd4;
        nxt.predicted = 1'b0;
        if (rd.valid)
        begin
            nxt.pc = rd.target;
        end
        else if (stall)
        begin
            nxt = cur;
        end
        else
        begin
            for (int i = 0; i < ENTRIES; i++)
            begin
                if (|ref_hist[i] && ref_pc[i] == cur.pc)
                begin
                    nxt.pc        = ref_target[i];
                    nxt.predicted = 1'b1;
                end
            end
        end
        return nxt;
    endfunction

    task automatic train(input rv_fetch_pkg::redirect_t rd);
        int     slot;
        logic   same;
        logic   age;

        slot = -1;
        for (int i = 0; i < ENTRIES; i++)
        begin
            if (|ref_hist[i] && ref_pc[i] == rd.branch_pc)
                slot = i;
        end
        same = (slot >= 0);
        if (!same)
        begin
            slot = 0;     // Oldest history wins with ties to the lowest index
            for (int i = 1; i < ENTRIES; i++)
            begin
                if (ref_hist[i] < ref_hist[slot])
                    slot = i;
            end
        end
        age = ref_target[slot] != rd.target;
        for (int i = 0; i < ENTRIES; i++)
        begin
            if (i != slot && age)
                ref_hist[i] = ref_hist[i] >> 1;
        end
        if (same)
            ref_hist[slot] = {1'b1, ref_hist[slot][ENTRIES-1:1]};
        else
            ref_hist[slot] = {1'b1, {(ENTRIES-1){1'b0}}};
        ref_pc[slot]     = rd.branch_pc;
        ref_target[slot] = rd.target;
    endtask

    always @(posedge i_clk)
    begin
        if (armed)
        begin
            check_count = check_count + 1;
            if (i_fetch !== expected)
            begin
                error_count = error_count + 1;
                $display(
                    "CHECK FAILED time=%0t: pc expected %h got %h, predicted expected %b got %b",
                    $time, expected.pc, i_fetch.pc, expected.predicted, i_fetch.predicted);
            end
        end

        if (!i_reset_n)
        begin
            for (int i = 0; i < ENTRIES; i++)
            begin
                ref_pc[i]     = '0;
                ref_target[i] = '0;
                ref_hist[i]   = '0;
            end
            expected.pc        = `RV_RESET_PC;
            expected.predicted = 1'b0;
        end
        else
        begin
            // Lookup sees the table before this edge's training
            expected = next_fetch(expected, i_redirect, i_stall);
            if (i_redirect.valid)
                train(i_redirect);
        end
        armed = 1'b1;
    end

endmodule

/* logic/rv_fetch.sv */
`timescale 1ns/1ps

`include "rv_fetch_cfg.svh"

module rv_fetch
(
    input   logic                       i_clk,
    input   logic                       i_reset_n,
    input   rv_fetch_pkg::redirect_t    i_redirect,
    input   logic                       i_stall,
    output  rv_fetch_pkg::fetch_t       o_fetch
);

    logic [`RV_IADDR_BITS-1:0]  pc_current;
    logic [`RV_IADDR_BITS-1:0]  pc_new;
    logic                       pc_predicted;

    rv_fetch_pc u_pc
    (
        .i_clk              (i_clk),
        .i_reset_n          (i_reset_n),
        .i_redirect         (i_redirect),
        .i_stall            (i_stall),
        .i_pc_new           (pc_new),
        .i_pc_predicted     (pc_predicted),
        .o_pc_current       (pc_current),
        .o_fetch            (o_fetch)
    );

    // Redirect also trains the BTB
    rv_fetch_branch_pred
    #(
        .IADDR_SPACE_BITS   (`RV_IADDR_BITS),
        .TABLE_SIZE_BITS    (`RV_BTB_SIZE_BITS)
    )
    u_bp
    (
        .i_clk              (i_clk),
        .i_reset_n          (i_reset_n),
        .i_pc_current       (pc_current),
        .i_redirect         (i_redirect),
        .o_pc_new           (pc_new),
        .o_pc_predicted     (pc_predicted)
    );

endmodule

/* logic/rv_fetch_pc.sv */
`timescale 1ns/1ps

`include "rv_fetch_cfg.svh"

module rv_fetch_pc
(
    input   logic                           i_clk,
    input   logic                           i_reset_n,
    input   rv_fetch_pkg::redirect_t        i_redirect,
    input   logic                           i_stall,
    input   logic [`RV_IADDR_BITS-1:0]      i_pc_new,
    input   logic                           i_pc_predicted,
    output  logic [`RV_IADDR_BITS-1:0]      o_pc_current,
    output  rv_fetch_pkg::fetch_t           o_fetch
);

    logic [`RV_IADDR_BITS-1:0]  pc;
    logic [`RV_IADDR_BITS-1:0]  pc_next;
    logic [`RV_IADDR_BITS-1:0]  pc_seq;
    logic                       predicted;
    logic                       predicted_next;

    assign pc_seq = pc + `RV_IADDR_BITS'(4);

    always_comb
    begin
        if (i_redirect.valid)
        begin
            // Execute wins, even under stall
            pc_next        = i_redirect.target;
            predicted_next = 1'b0;
        end
        else if (i_stall)
        begin
            pc_next        = pc;
            predicted_next = predicted;
        end
        else if (i_pc_predicted)
        begin
            pc_next        = i_pc_new;
            predicted_next = 1'b1;
        end
        else
        begin
            pc_next        = pc_seq;
            predicted_next = 1'b0;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            pc        <= `RV_RESET_PC;
            predicted <= 1'b0;
        end
        else
        begin
            pc        <= pc_next;
            predicted <= predicted_next;
        end
    end

    assign o_pc_current      = pc;     // BTB lookup address
    assign o_fetch.pc        = pc;
    assign o_fetch.predicted = predicted;

endmodule

/* logic/rv_fetch_branch_pred.sv */
`timescale 1ns/1ps

module rv_fetch_branch_pred
#(
    parameter int IADDR_SPACE_BITS  = 32,
    parameter int TABLE_SIZE_BITS   = 4
)
(
    input   logic                           i_clk,
    input   logic                           i_reset_n,
    input   logic [IADDR_SPACE_BITS-1:0]    i_pc_current,
    input   rv_fetch_pkg::redirect_t        i_redirect,
    output  logic [IADDR_SPACE_BITS-1:0]    o_pc_new,
    output  logic                           o_pc_predicted
);

    localparam int TABLE_SIZE = 2 ** TABLE_SIZE_BITS;

    logic [IADDR_SPACE_BITS-1:0]    btb_pc     [TABLE_SIZE];
    logic [IADDR_SPACE_BITS-1:0]    btb_target [TABLE_SIZE];
    logic [TABLE_SIZE-1:0]          btb_hist   [TABLE_SIZE];     // Recency with MSB newest

    logic [TABLE_SIZE*TABLE_SIZE-1:0]   hist_flat;
    logic [TABLE_SIZE-1:0]              entry_valid;
    logic [TABLE_SIZE-1:0]              lookup_hit;
    logic [TABLE_SIZE-1:0]              same_hit;

    logic [TABLE_SIZE_BITS-1:0]     hit_idx;
    logic [TABLE_SIZE_BITS-1:0]     same_idx;
    logic [TABLE_SIZE_BITS-1:0]     free_idx;
    logic [TABLE_SIZE_BITS-1:0]     upd_idx;
    logic                           have_same;
    logic                           age_others;

    genvar g;
    generate
        for (g = 0; g < TABLE_SIZE; g++)
        begin : g_entry
            assign hist_flat[g*TABLE_SIZE +: TABLE_SIZE] = btb_hist[g];
            assign entry_valid[g] = |btb_hist[g];
            assign lookup_hit[g]  = entry_valid[g] && (btb_pc[g] == i_pc_current);
            assign same_hit[g]    = entry_valid[g] && (btb_pc[g] == i_redirect.branch_pc);
        end
    endgenerate

    // Victim is the entry with the oldest history
    min_idx
    #(
        .ELEMENT_WIDTH  (TABLE_SIZE),
        .INDEX_WIDTH    (TABLE_SIZE_BITS),
        .ELEMENT_COUNT  (TABLE_SIZE)
    )
    u_min
    (
        .i_elements     (hist_flat),
        .o_min_idx      (free_idx)
    );

    // At most one entry holds a given PC, so a plain OR decodes the index
    always_comb
    begin
        hit_idx  = '0;
        same_idx = '0;
        for (int i = 0; i < TABLE_SIZE; i++)
        begin
            if (lookup_hit[i])
                hit_idx = hit_idx | TABLE_SIZE_BITS'(i);
            if (same_hit[i])
                same_idx = same_idx | TABLE_SIZE_BITS'(i);
        end
    end

    assign o_pc_new       = btb_target[hit_idx];
    assign o_pc_predicted = |lookup_hit;

    assign have_same  = |same_hit;
    assign upd_idx    = have_same ? same_idx : free_idx;
    assign age_others = i_redirect.valid && (btb_target[upd_idx] != i_redirect.target);

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            for (int i = 0; i < TABLE_SIZE; i++)
            begin
                btb_pc[i]     <= '0;
                btb_target[i] <= '0;
                btb_hist[i]   <= '0;     // All entries invalid
            end
        end
        else if (i_redirect.valid)
        begin
            for (int i = 0; i < TABLE_SIZE; i++)
            begin
                if (TABLE_SIZE_BITS'(i) == upd_idx)
                begin
                    btb_pc[i]     <= i_redirect.branch_pc;
                    btb_target[i] <= i_redirect.target;
                    if (have_same)
                        btb_hist[i] <= {1'b1, btb_hist[i][TABLE_SIZE-1:1]};
                    else
                        btb_hist[i] <= {1'b1, {(TABLE_SIZE-1){1'b0}}};
                end
                else if (age_others)
                begin
                    btb_hist[i] <= btb_hist[i] >> 1;
                end
            end
        end
    end

endmodule

/* logic/min_idx.sv */
`timescale 1ns/1ps

module min_idx
#(
    parameter int ELEMENT_WIDTH     = 16,
    parameter int INDEX_WIDTH       = 4,
    parameter int ELEMENT_COUNT     = 16
)
(
    input   logic [ELEMENT_WIDTH*ELEMENT_COUNT-1:0]  i_elements,
    output  logic [INDEX_WIDTH-1:0]                 o_min_idx
);

    // Leaves rounded up to a power of two
    localparam int LEVELS = (ELEMENT_COUNT > 1) ? $clog2(ELEMENT_COUNT) : 0;
    localparam int LEAVES = 2 ** LEVELS;
    localparam int NODES  = 2 * LEAVES - 1;

    // Node n has children 2n+1 and 2n+2
    logic [ELEMENT_WIDTH-1:0]   node_val [NODES];
    logic [INDEX_WIDTH-1:0]     node_idx [NODES];

    genvar i;
    generate
        for (i = 0; i < LEAVES; i++)
        begin : g_leaf
            if (i < ELEMENT_COUNT)
            begin : g_real
                assign node_val[LEAVES-1+i] = i_elements[i*ELEMENT_WIDTH +: ELEMENT_WIDTH];
            end
            else
            begin : g_pad
                // Padding sits to the right and never beats a real element
                assign node_val[LEAVES-1+i] = '1;
            end
            assign node_idx[LEAVES-1+i] = INDEX_WIDTH'(i);
        end

        for (i = 0; i < LEAVES - 1; i++)
        begin : g_node
            logic take_right;

            // Equal values keep the lower index
            assign take_right  = node_val[2*i+2] < node_val[2*i+1];
            assign node_val[i] = take_right ? node_val[2*i+2] : node_val[2*i+1];
            assign node_idx[i] = take_right ? node_idx[2*i+2] : node_idx[2*i+1];
        end
    endgenerate

    assign o_min_idx = node_idx[0];

endmodule

/* logic/rv_fetch_pkg.sv */
`include "rv_fetch_cfg.svh"

package rv_fetch_pkg;

    // Resolved taken branch from execute
    typedef struct packed
    {
        logic                           valid;
        logic [`RV_IADDR_BITS-1:0]      branch_pc;
        logic [`RV_IADDR_BITS-1:0]      target;
    } redirect_t;

    typedef struct packed
    {
        logic [`RV_IADDR_BITS-1:0]      pc;
        logic                           predicted;     // Reached through a BTB hit
    } fetch_t;

endpackage

/* include/rv_fetch_cfg.svh */
`ifndef RV_FETCH_CFG_SVH
`define RV_FETCH_CFG_SVH

// Instruction address width
`define RV_IADDR_BITS       32

// BTB index width for 2**N entries
`define RV_BTB_SIZE_BITS    4

`define RV_RESET_PC         32'h0000_0000

`endif
